/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    parameter int xlen_default = 64;

    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes of the supported subset
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    // encoded as {funct7[5], funct3} so the decoder can cast directly
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_e;

    // same values as the branch funct3 field
    typedef enum logic [2:0] {
        br_eq  = 3'b000,
        br_ne  = 3'b001,
        br_lt  = 3'b100,
        br_ge  = 3'b101,
        br_ltu = 3'b110,
        br_geu = 3'b111
    } br_cond_e;

endpackage

`default_nettype wire

/* src/fetch_unit.sv */
`default_nettype none
`timescale 1ns/10ps

module fetch_unit import rv_pkg::*; #(
    parameter int              XLEN     = 64,
    parameter logic [XLEN-1:0] RESET_PC = 'h8000_0000
) (
    input  logic            inst_selfdefine,
    input  logic            reset,
    input  logic            if_ready,
    input  inst_t           if_data_read,
    input  logic [XLEN-1:0] next_pc,
    output logic            if_valid,
    output logic [XLEN-1:0] if_addr,
    output logic [XLEN-1:0] pc,
    output inst_t           inst,
    output logic            inst_valid
);

    typedef enum logic {
        st_request,
        st_execute
    } fetch_state_e;

    fetch_state_e state;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            state <= st_request;
            pc    <= RESET_PC;
        end else if (state == st_request) begin
            if (if_ready) begin
                state <= st_execute;
            end
        end else begin
            // instruction executes this cycle, move on
            state <= st_request;
            pc    <= next_pc;
        end
    end

    // capture on the accepting edge only
    always_ff @(posedge inst_selfdefine) begin
        if (state == st_request && if_ready) begin
            inst <= if_data_read;
        end
    end

    assign if_valid   = (state == st_request);
    assign if_addr    = pc;
    assign inst_valid = (state == st_execute);

endmodule

`default_nettype wire

/* src/inst_decoder.sv */
`default_nettype none
`timescale 1ns/10ps

module inst_decoder import rv_pkg::*; #(
    parameter int XLEN = 64
) (
    input  inst_t           inst,
    output reg_idx_t        rs1_idx,
    output reg_idx_t        rs2_idx,
    output reg_idx_t        rd_idx,
    output logic            rd_wen,
    output logic [XLEN-1:0] imm,
    output alu_op_e         alu_op,
    output logic            src_a_pc,
    output logic            src_b_imm,
    output logic            is_branch,
    output br_cond_e        br_cond,
    output logic            is_jal,
    output logic            is_jalr,
    output logic            is_lui
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] imm_sel;
    logic        imm_ok;
    logic        imm_alt;
    logic        reg_ok;

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign rd_idx  = inst[11:7];
    assign rs1_idx = inst[19:15];
    assign rs2_idx = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    assign imm = {{(XLEN-32){imm_sel[31]}}, imm_sel};

    // rv64 shift immediates carry funct6 in [31:26]
    always_comb begin
        case (funct3)
            3'b001:  imm_ok = (inst[31:26] == 6'b000000);
            3'b101:  imm_ok = (inst[31:26] == 6'b000000) || (inst[31:26] == 6'b010000);
            default: imm_ok = 1'b1;
        endcase
    end

    // only srai uses the alternate bit among the immediates
    assign imm_alt = (funct3 == 3'b101) && inst[30];

    assign reg_ok = (funct7 == 7'b0000000) ||
                    ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));

    always_comb begin
        rd_wen    = 1'b0;
        imm_sel   = imm_i;
        alu_op    = alu_add;
        src_a_pc  = 1'b0;
        src_b_imm = 1'b0;
        is_branch = 1'b0;
        br_cond   = br_eq;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        is_lui    = 1'b0;
        case (opcode)
            opc_lui: begin
                rd_wen  = 1'b1;
                imm_sel = imm_u;
                is_lui  = 1'b1;
            end
            opc_auipc: begin
                rd_wen    = 1'b1;
                imm_sel   = imm_u;
                src_a_pc  = 1'b1;
                src_b_imm = 1'b1;
            end
            opc_jal: begin
                rd_wen  = 1'b1;
                imm_sel = imm_j;
                is_jal  = 1'b1;
            end
            opc_jalr: begin
                // target comes from the alu as rs1 + imm
                if (funct3 == 3'b000) begin
                    rd_wen    = 1'b1;
                    src_b_imm = 1'b1;
                    is_jalr   = 1'b1;
                end
            end
            opc_branch: begin
                imm_sel = imm_b;
                if (funct3[2:1] != 2'b01) begin
                    is_branch = 1'b1;
                    br_cond   = br_cond_e'(funct3);
                end
            end
            opc_op_imm: begin
                if (imm_ok) begin
                    rd_wen    = 1'b1;
                    src_b_imm = 1'b1;
                    alu_op    = alu_op_e'({imm_alt, funct3});
                end
            end
            opc_op: begin
                if (reg_ok) begin
                    rd_wen = 1'b1;
                    alu_op = alu_op_e'({funct7[5], funct3});
                end
            end
            default: begin
            end
        endcase
        // x0 is never written
        if (rd_idx == 5'd0) begin
            rd_wen = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/reg_file.sv */
`default_nettype none
`timescale 1ns/10ps

module reg_file import rv_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic            inst_selfdefine,
    input  logic            reset,
    input  reg_idx_t        rs1_idx,
    input  reg_idx_t        rs2_idx,
    input  logic            wen,
    input  reg_idx_t        wr_idx,
    input  logic [XLEN-1:0] wr_data,
    output logic [XLEN-1:0] rs1_data,
    output logic [XLEN-1:0] rs2_data
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // entry 0 keeps its reset value, the decoder never enables a write there
    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

endmodule

`default_nettype wire

/* src/exec_unit.sv */
`default_nettype none
`timescale 1ns/10ps

module exec_unit import rv_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] imm,
    input  alu_op_e         alu_op,
    input  logic            src_a_pc,
    input  logic            src_b_imm,
    input  logic            is_branch,
    input  br_cond_e        br_cond,
    input  logic            is_jal,
    input  logic            is_jalr,
    output logic [XLEN-1:0] alu_res,
    output logic [XLEN-1:0] next_pc
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [5:0]      shamt;
    logic            br_taken;

    assign op_a  = src_a_pc ? pc : rs1_data;
    assign op_b  = src_b_imm ? imm : rs2_data;
    assign shamt = op_b[5:0];

    always_comb begin
        case (alu_op)
            alu_add:  alu_res = op_a + op_b;
            alu_sub:  alu_res = op_a - op_b;
            alu_sll:  alu_res = op_a << shamt;
            alu_slt:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
            alu_xor:  alu_res = op_a ^ op_b;
            alu_srl:  alu_res = op_a >> shamt;
            alu_sra:  alu_res = $signed(op_a) >>> shamt;
            alu_or:   alu_res = op_a | op_b;
            alu_and:  alu_res = op_a & op_b;
            default:  alu_res = op_a + op_b;
        endcase
    end

    always_comb begin
        case (br_cond)
            br_eq:   br_taken = (rs1_data == rs2_data);
            br_ne:   br_taken = (rs1_data != rs2_data);
            br_lt:   br_taken = ($signed(rs1_data) < $signed(rs2_data));
            br_ge:   br_taken = ($signed(rs1_data) >= $signed(rs2_data));
            br_ltu:  br_taken = (rs1_data < rs2_data);
            br_geu:  br_taken = (rs1_data >= rs2_data);
            default: br_taken = 1'b0;
        endcase
    end

    // jalr target is the alu sum with bit 0 dropped
    always_comb begin
        if (is_jalr) begin
            next_pc = {alu_res[XLEN-1:1], 1'b0};
        end else if (is_jal || (is_branch && br_taken)) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc + XLEN'(4);
        end
    end

endmodule

`default_nettype wire

/* src/commit_stage.sv */
`default_nettype none
`timescale 1ns/10ps

module commit_stage import rv_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic            inst_selfdefine,
    input  logic            reset,
    input  logic            inst_valid,
    input  logic [XLEN-1:0] pc,
    input  inst_t           inst,
    input  reg_idx_t        rd_idx,
    input  logic            rd_wen,
    input  logic [XLEN-1:0] alu_res,
    input  logic [XLEN-1:0] imm,
    input  logic            is_jal,
    input  logic            is_jalr,
    input  logic            is_lui,
    output logic [XLEN-1:0] wr_data,
    output logic            wen,
    output logic            commit_valid,
    output logic [XLEN-1:0] commit_pc,
    output inst_t           commit_inst,
    output logic            commit_wen,
    output reg_idx_t        commit_rd,
    output logic [XLEN-1:0] commit_data
);

    // link value for jumps
    assign wr_data = (is_jal || is_jalr) ? pc + XLEN'(4) :
                     is_lui              ? imm :
                                           alu_res;
    assign wen     = rd_wen && inst_valid;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            commit_valid <= 1'b0;
            commit_wen   <= 1'b0;
        end else begin
            commit_valid <= inst_valid;
            commit_wen   <= wen;
        end
    end

    always_ff @(posedge inst_selfdefine) begin
        if (inst_valid) begin
            commit_pc   <= pc;
            commit_inst <= inst;
            commit_rd   <= rd_idx;
            commit_data <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* src/core_top.sv */
`default_nettype none
`timescale 1ns/10ps

module core_top import rv_pkg::*; #(
    parameter int              XLEN     = xlen_default,
    parameter logic [XLEN-1:0] RESET_PC = 'h8000_0000
) (
    input  logic            inst_selfdefine,
    input  logic            reset,
    input  logic            if_ready,
    input  inst_t           if_data_read,
    output logic            if_valid,
    output logic [XLEN-1:0] if_addr,
    output logic            commit_valid,
    output logic [XLEN-1:0] commit_pc,
    output inst_t           commit_inst,
    output logic            commit_wen,
    output reg_idx_t        commit_rd,
    output logic [XLEN-1:0] commit_data
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_pc;
    inst_t           inst;
    logic            inst_valid;

    reg_idx_t        rs1_idx;
    reg_idx_t        rs2_idx;
    reg_idx_t        rd_idx;
    logic            rd_wen;
    logic [XLEN-1:0] imm;
    alu_op_e         alu_op;
    logic            src_a_pc;
    logic            src_b_imm;
    logic            is_branch;
    br_cond_e        br_cond;
    logic            is_jal;
    logic            is_jalr;
    logic            is_lui;

    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] wr_data;
    logic            wen;

    fetch_unit #(
        .XLEN     (XLEN),
        .RESET_PC (RESET_PC)
    ) fetch_i (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .if_ready        (if_ready),
        .if_data_read    (if_data_read),
        .next_pc         (next_pc),
        .if_valid        (if_valid),
        .if_addr         (if_addr),
        .pc              (pc),
        .inst            (inst),
        .inst_valid      (inst_valid)
    );

    inst_decoder #(
        .XLEN (XLEN)
    ) decoder_i (
        .inst      (inst),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .rd_idx    (rd_idx),
        .rd_wen    (rd_wen),
        .imm       (imm),
        .alu_op    (alu_op),
        .src_a_pc  (src_a_pc),
        .src_b_imm (src_b_imm),
        .is_branch (is_branch),
        .br_cond   (br_cond),
        .is_jal    (is_jal),
        .is_jalr   (is_jalr),
        .is_lui    (is_lui)
    );

    reg_file #(
        .XLEN (XLEN)
    ) regs_i (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .rs1_idx         (rs1_idx),
        .rs2_idx         (rs2_idx),
        .wen             (wen),
        .wr_idx          (rd_idx),
        .wr_data         (wr_data),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data)
    );

    exec_unit #(
        .XLEN (XLEN)
    ) exec_i (
        .pc        (pc),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .imm       (imm),
        .alu_op    (alu_op),
        .src_a_pc  (src_a_pc),
        .src_b_imm (src_b_imm),
        .is_branch (is_branch),
        .br_cond   (br_cond),
        .is_jal    (is_jal),
        .is_jalr   (is_jalr),
        .alu_res   (alu_res),
        .next_pc   (next_pc)
    );

    commit_stage #(
        .XLEN (XLEN)
    ) commit_i (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .inst_valid      (inst_valid),
        .pc              (pc),
        .inst            (inst),
        .rd_idx          (rd_idx),
        .rd_wen          (rd_wen),
        .alu_res         (alu_res),
        .imm             (imm),
        .is_jal          (is_jal),
        .is_jalr         (is_jalr),
        .is_lui          (is_lui),
        .wr_data         (wr_data),
        .wen             (wen),
        .commit_valid    (commit_valid),
        .commit_pc       (commit_pc),
        .commit_inst     (commit_inst),
        .commit_wen      (commit_wen),
        .commit_rd       (commit_rd),
        .commit_data     (commit_data)
    );

endmodule

`default_nettype wire

/* sim/rv_ref_model.svh */
`ifndef rv_ref_model_svh
`define rv_ref_model_svh

// architectural state of the reference
logic [63:0] ref_regs [32];
logic [63:0] ref_pc;

task automatic init_reference();
    for (int i = 0; i < 32; i++) begin
        ref_regs[i] = '0;
    end
    ref_pc = reset_pc;
endtask

// shared by op and op-imm, alt selects sub and sra
function automatic logic [63:0] alu_result(
    input logic [2:0]  f3,
    input logic        alt,
    input logic [63:0] a,
    input logic [63:0] b
);
    logic [63:0] r;
    case (f3)
        3'b000: begin
            if (alt) begin
                r = a - b;
            end else begin
                r = a + b;
            end
        end
        3'b001: r = a << b[5:0];
        3'b010: r = {63'd0, $signed(a) < $signed(b)};
        3'b011: r = {63'd0, a < b};
        3'b100: r = a ^ b;
        3'b101: begin
            if (alt) begin
                r = $signed(a) >>> b[5:0];
            end else begin
                r = a >> b[5:0];
            end
        end
        3'b110: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

// executes one word on the reference state and returns the expected write-back
task automatic predict_commit(
    input  logic [31:0] w,
    output logic        wen,
    output logic [4:0]  rd,
    output logic [63:0] data
);
    logic [6:0]  opcode;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [63:0] rs1v;
    logic [63:0] rs2v;
    logic [63:0] imm_i;
    logic [63:0] imm_u;
    logic [63:0] imm_b;
    logic [63:0] imm_j;
    logic [63:0] nxt;
    logic        taken;

    opcode = w[6:0];
    f3     = w[14:12];
    f7     = w[31:25];
    rd     = w[11:7];
    rs1v   = ref_regs[w[19:15]];
    rs2v   = ref_regs[w[24:20]];
    imm_i  = {{52{w[31]}}, w[31:20]};
    imm_u  = {{32{w[31]}}, w[31:12], 12'b0};
    imm_b  = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_j  = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    nxt    = ref_pc + 64'd4;
    wen    = 1'b0;
    data   = '0;
    taken  = 1'b0;

    case (opcode)
        7'b0110111: begin
            wen  = 1'b1;
            data = imm_u;
        end
        7'b0010111: begin
            wen  = 1'b1;
            data = ref_pc + imm_u;
        end
        7'b1101111: begin
            wen  = 1'b1;
            data = ref_pc + 64'd4;
            nxt  = ref_pc + imm_j;
        end
        7'b1100111: begin
            if (f3 == 3'b000) begin
                wen  = 1'b1;
                data = ref_pc + 64'd4;
                nxt  = (rs1v + imm_i) & ~64'd1;
            end
        end
        7'b1100011: begin
            case (f3)
                3'b000:  taken = (rs1v == rs2v);
                3'b001:  taken = (rs1v != rs2v);
                3'b100:  taken = ($signed(rs1v) < $signed(rs2v));
                3'b101:  taken = ($signed(rs1v) >= $signed(rs2v));
                3'b110:  taken = (rs1v < rs2v);
                3'b111:  taken = (rs1v >= rs2v);
                default: taken = 1'b0;
            endcase
            if (taken) begin
                nxt = ref_pc + imm_b;
            end
        end
        7'b0010011: begin
            if (f3 == 3'b001) begin
                wen = (w[31:26] == 6'b000000);
            end else if (f3 == 3'b101) begin
                wen = (w[31:26] == 6'b000000) || (w[31:26] == 6'b010000);
            end else begin
                wen = 1'b1;
            end
            data = alu_result(f3, (f3 == 3'b101) && w[30], rs1v, imm_i);
        end
        7'b0110011: begin
            if (f7 == 7'b0000000) begin
                wen  = 1'b1;
                data = alu_result(f3, 1'b0, rs1v, rs2v);
            end else if (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101)) begin
                wen  = 1'b1;
                data = alu_result(f3, 1'b1, rs1v, rs2v);
            end
        end
        default: begin
        end
    endcase

    if (rd == 5'd0) begin
        wen = 1'b0;
    end
    if (wen) begin
        ref_regs[rd] = data;
    end
    ref_pc = nxt;
endtask

`endif

/* sim/tb_core.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_core import rv_pkg::*; ();

    localparam int          clk_period      = 100;
    localparam int          drive_delay     = 5;
    localparam int unsigned seed            = 32'h62f5be31;
    localparam int          max_ready_delay = 3;
    localparam int          num_insts       = 400;
    localparam int          timeout_cycles  = 20;
    localparam logic [63:0] reset_pc        = 64'h0000_0000_8000_0000;

    logic        inst_selfdefine;
    logic        reset;
    logic        if_ready;
    inst_t       if_data_read;
    logic        if_valid;
    logic [63:0] if_addr;
    logic        commit_valid;
    logic [63:0] commit_pc;
    inst_t       commit_inst;
    logic        commit_wen;
    reg_idx_t    commit_rd;
    logic [63:0] commit_data;

    int value_errors = 0;
    int timeout_errors = 0;

    `include "rv_ref_model.svh"

    core_top #(
        .XLEN     (64),
        .RESET_PC (reset_pc)
    ) dut_i (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .if_ready        (if_ready),
        .if_data_read    (if_data_read),
        .if_valid        (if_valid),
        .if_addr         (if_addr),
        .commit_valid    (commit_valid),
        .commit_pc       (commit_pc),
        .commit_inst     (commit_inst),
        .commit_wen      (commit_wen),
        .commit_rd       (commit_rd),
        .commit_data     (commit_data)
    );

    initial begin
        inst_selfdefine = 1'b0;
        forever begin
            #(clk_period / 2) inst_selfdefine = ~inst_selfdefine;
        end
    end

    task automatic tick();
        @(posedge inst_selfdefine);
        #drive_delay;
    endtask

    task automatic check_value(input logic ok, input string msg);
        assert (ok) else begin
            value_errors++;
            $display("FAIL time %0t: %s", $time, msg);
        end
    endtask

    // mostly the supported subset with small branch and jump offsets
    function automatic inst_t random_inst();
        int unsigned kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        logic [12:0] off_b;
        logic [20:0] off_j;
        inst_t       w;

        kind  = $urandom % 100;
        rd    = 5'($urandom % 8);
        rs1   = 5'($urandom % 8);
        rs2   = 5'($urandom % 8);
        f3    = 3'($urandom % 8);
        imm12 = 12'($urandom);
        if (kind < 8) begin
            w = {20'($urandom), rd, 7'b0110111};
        end else if (kind < 14) begin
            w = {20'($urandom), rd, 7'b0010111};
        end else if (kind < 40) begin
            if (f3 == 3'b001 || f3 == 3'b101) begin
                imm12[11:6] = 6'b000000;
                if (f3 == 3'b101 && $urandom % 2 == 1) begin
                    imm12[11:6] = 6'b010000;
                end
                if ($urandom % 10 == 0) begin
                    imm12[11:6] = 6'($urandom);
                end
            end
            w = {imm12, rs1, f3, rd, 7'b0010011};
        end else if (kind < 64) begin
            f7 = 7'b0000000;
            if ($urandom % 2 == 1) begin
                f7 = 7'b0100000;
            end
            if ($urandom % 10 == 0) begin
                f7 = 7'($urandom);
            end
            w = {f7, rs2, rs1, f3, rd, 7'b0110011};
        end else if (kind < 80) begin
            off_b = 13'(($urandom % 17) * 4) - 13'd32;
            w = {off_b[12], off_b[10:5], rs2, rs1, f3, off_b[4:1], off_b[11], 7'b1100011};
        end else if (kind < 86) begin
            off_j = 21'(($urandom % 17) * 4) - 21'd32;
            w = {off_j[20], off_j[10:1], off_j[11], off_j[19:12], rd, 7'b1101111};
        end else if (kind < 92) begin
            if ($urandom % 8 != 0) begin
                f3 = 3'b000;
            end
            // odd offsets exercise the cleared target bit
            imm12 = 12'($urandom % 64) - 12'd32;
            w = {imm12, rs1, f3, rd, 7'b1100111};
        end else begin
            w = $urandom;
        end
        return w;
    endfunction

    task automatic wait_for_request(output logic ok);
        int cycles;
        cycles = 0;
        while (!if_valid && cycles < timeout_cycles) begin
            tick();
            cycles++;
        end
        ok = if_valid;
        if (!ok) begin
            timeout_errors++;
            $display("timeout: the core made no fetch request within %0d cycles",
                     timeout_cycles);
        end
    endtask

    task automatic wait_for_commit(output int cycles, output logic ok);
        cycles = 0;
        while (!commit_valid && cycles < timeout_cycles) begin
            tick();
            if_ready = 1'b0;
            cycles++;
        end
        ok = commit_valid;
        if (!ok) begin
            timeout_errors++;
            $display("timeout: an accepted instruction did not commit within %0d cycles",
                     timeout_cycles);
        end
    endtask

    task automatic run_one_instruction(output logic ok);
        int unsigned delay;
        int          cycles;
        logic [63:0] req_addr;
        inst_t       word;
        logic        exp_wen;
        logic [4:0]  exp_rd;
        logic [63:0] exp_data;

        wait_for_request(ok);
        if (ok) begin
            req_addr = if_addr;
            check_value(if_addr == ref_pc,
                        $sformatf("if_addr %h, expected %h", if_addr, ref_pc));
            if_ready = 1'b0;
            delay = $urandom % (max_ready_delay + 1);
            repeat (delay) begin
                tick();
                check_value(if_valid, "if_valid dropped while if_ready was low");
                check_value(if_addr == req_addr,
                            $sformatf("if_addr moved to %h, held %h", if_addr, req_addr));
                check_value(!commit_valid, "commit without an accepted fetch");
            end
            word = random_inst();
            if_ready = 1'b1;
            if_data_read = word;
            tick();
            // if_valid is low now, so a ready pulse has to be ignored
            if_ready = 1'($urandom % 2);
            if_data_read = $urandom;
            predict_commit(word, exp_wen, exp_rd, exp_data);
            wait_for_commit(cycles, ok);
            if (ok) begin
                check_value(cycles == 1,
                            $sformatf("commit %0d cycles after execute, expected 1", cycles));
                check_value(commit_pc == req_addr,
                            $sformatf("commit_pc %h, expected %h", commit_pc, req_addr));
                check_value(commit_inst == word,
                            $sformatf("commit_inst %h, expected %h", commit_inst, word));
                check_value(commit_wen == exp_wen,
                            $sformatf("commit_wen %b, expected %b for %h",
                                      commit_wen, exp_wen, word));
                if (exp_wen) begin
                    check_value(commit_rd == exp_rd,
                                $sformatf("commit_rd %0d, expected %0d", commit_rd, exp_rd));
                    check_value(commit_data == exp_data,
                                $sformatf("commit_data %h, expected %h for %h",
                                          commit_data, exp_data, word));
                end
                check_value(if_valid, "no new fetch request in the commit cycle");
            end
        end
    endtask

    initial begin
        logic ok;
        int   n;

        void'($urandom(seed));
        reset        = 1'b1;
        if_ready     = 1'b0;
        if_data_read = '0;
        init_reference();
        repeat (3) begin
            tick();
        end
        reset = 1'b0;
        check_value(if_valid, "if_valid low after reset");
        check_value(!commit_valid, "commit_valid high after reset");

        ok = 1'b1;
        n  = 0;
        while (ok && n < num_insts) begin
            run_one_instruction(ok);
            n++;
        end

        $display("%0d instructions, %0d value errors, %0d timeouts",
                 n, value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+sim
src/rv_pkg.sv
src/fetch_unit.sv
src/inst_decoder.sv
src/reg_file.sv
src/exec_unit.sv
src/commit_stage.sv
src/core_top.sv
sim/tb_core.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_core -f vlog.f -Mdir obj_dir -o sim_core

./obj_dir/sim_core | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi

echo "simulation finished without errors"
exit 0
